// ==== compile.f ====
+incdir+source
source/mipsIsaPkg.sv
source/mipsBusPkg.sv
source/controlDecoder.sv
source/aluUnit.sv
source/regFile.sv
source/pcUnit.sv
source/mipsCore.sv
test/coreTb.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator, run it and judge the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f compile.f --top-module coreTb -o coreSim \
  || { echo "verilator build failed"; exit 1; }
./obj_dir/coreSim > sim.log 2>&1 || echo "simulator exited with an error"
cat sim.log
grep -qx "Test OK" sim.log && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// ==== source/aluUnit.sv ====
/* Combinational 32-bit ALU. zero flags a == b for every operation, not a
   zero result. */
`timescale 1ns/1ps
`include "mips_consts.svh"

module aluUnit import mipsIsaPkg::*; (
  input  logic [`XLEN-1:0] a,
  input  logic [`XLEN-1:0] b,
  input  aluOpT            op,
  output logic [`XLEN-1:0] result,
  output logic             zero
);

  // signed compare for slt
  logic aLessB;

  assign aLessB = $signed(a) < $signed(b);

  always_comb begin
    case (op)
      aluAdd:  result = a + b;
      aluSub:  result = a - b;
      aluAnd:  result = a & b;
      aluOr:   result = a | b;
      aluSlt:  result = {{(`XLEN-1){1'b0}}, aLessB};
      // operand b straight through
      aluPass: result = b;
      default: result = '0;
    endcase
  end

  // beq uses this regardless of op
  assign zero = (a == b);

endmodule

// ==== source/controlDecoder.sv ====
/* Purely combinational decode of opcode and funct. Anything outside the
   supported subset yields an inactive control word with no writes. */
`timescale 1ns/1ps

module controlDecoder import mipsIsaPkg::*, mipsBusPkg::*; (
  input  instrT instr,
  output ctrlT  ctrl
);

  // ====================================================================
  // main decode
  // ====================================================================
  always_comb begin
    // inactive default
    ctrl       = '0;
    ctrl.aluOp = aluPass;

    case (instr.op)
      opRtype: begin
        // funct picks the ALU operation
        case (instr.funct)
          fnAdd: begin
            ctrl.regWrite = 1'b1;
            ctrl.regDst   = 1'b1;
            ctrl.aluOp    = aluAdd;
          end
          fnSub: begin
            ctrl.regWrite = 1'b1;
            ctrl.regDst   = 1'b1;
            ctrl.aluOp    = aluSub;
          end
          fnAnd: begin
            ctrl.regWrite = 1'b1;
            ctrl.regDst   = 1'b1;
            ctrl.aluOp    = aluAnd;
          end
          fnOr: begin
            ctrl.regWrite = 1'b1;
            ctrl.regDst   = 1'b1;
            ctrl.aluOp    = aluOr;
          end
          fnSlt: begin
            ctrl.regWrite = 1'b1;
            ctrl.regDst   = 1'b1;
            ctrl.aluOp    = aluSlt;
          end
          // jr writes nothing, only redirects
          fnJr:    ctrl.jumpReg = 1'b1;
          default: ;
        endcase
      end
      opLw: begin
        // address = rs + simm
        ctrl.regWrite  = 1'b1;
        ctrl.aluSrcImm = 1'b1;
        ctrl.memRead   = 1'b1;
        ctrl.memToReg  = 1'b1;
        ctrl.aluOp     = aluAdd;
      end
      opSw: begin
        ctrl.aluSrcImm = 1'b1;
        ctrl.memWrite  = 1'b1;
        ctrl.aluOp     = aluAdd;
      end
      opBeq: begin
        // equality comes from the ALU zero flag
        ctrl.branch = 1'b1;
        ctrl.aluOp  = aluSub;
      end
      opJ:     ctrl.jump = 1'b1;
      opJal: begin
        ctrl.jump     = 1'b1;
        ctrl.link     = 1'b1;
        ctrl.regWrite = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

// ==== source/mipsBusPkg.sv ====
/* Datapath and port records of the core. Data-memory addresses are word
   addresses, byte lanes are not modelled. */
`include "mips_consts.svh"

package mipsBusPkg;
  import mipsIsaPkg::*;

  // decoded control word, one per instruction
  typedef struct packed {
    logic  regWrite;
    logic  regDst;      // 1 selects rd, 0 selects rt
    logic  aluSrcImm;   // second operand from immediate
    logic  memRead;
    logic  memWrite;
    logic  memToReg;
    logic  branch;
    logic  jump;
    logic  jumpReg;
    logic  link;        // jal return address write
    aluOpT aluOp;
  } ctrlT;

  // data memory request, answered in the same cycle
  typedef struct packed {
    logic [`DMEM_AW-1:0] addr;
    logic [`XLEN-1:0]    wdata;
    logic                we;
    logic                re;
  } dmemReqT;

  // register write-back, also the observable test port
  typedef struct packed {
    logic             en;
    logic [4:0]       addr;
    logic [`XLEN-1:0] data;
  } wbT;

endpackage

// ==== source/mipsCore.sv ====
/* Single-cycle MIPS core. Both memories must answer combinationally in the
   same cycle; no stalls. Memory strobes and wb.en are held low in reset. */
`timescale 1ns/1ps
`include "mips_consts.svh"

module mipsCore import mipsIsaPkg::*, mipsBusPkg::*; (
  input  logic             clk,
  input  logic             rst,
  output logic [`XLEN-1:0] instrAddr,
  input  instrT            instr,
  output dmemReqT          dmemReq,
  input  logic [`XLEN-1:0] dmemRdata,
  output wbT               wb
);

  // ====================================================================
  // internal signals
  // ====================================================================
  instrU            instrView;
  ctrlT             ctrl;
  logic [`XLEN-1:0] rsData;
  logic [`XLEN-1:0] rtData;
  logic [`XLEN-1:0] immExt;
  logic [`XLEN-1:0] aluB;
  logic [`XLEN-1:0] aluResult;
  logic             aluZero;
  logic [`XLEN-1:0] linkAddr;
  logic [4:0]       destReg;
  logic [`XLEN-1:0] wbData;

  // I and J fields as overlays of the same word
  assign instrView.r = instr;

  controlDecoder controlDecoder_inst (
    .instr (instr),
    .ctrl  (ctrl)
  );

  // register write comes back from the wb port
  regFile regFile_inst (
    .clk    (clk),
    .rst    (rst),
    .rs     (instr.rs),
    .rt     (instr.rt),
    .wb     (wb),
    .rsData (rsData),
    .rtData (rtData)
  );

  // ====================================================================
  // execute
  // ====================================================================
  assign immExt = {{(`XLEN-16){instrView.i.imm[15]}}, instrView.i.imm};
  // rt or sign-extended immediate
  assign aluB   = ctrl.aluSrcImm ? immExt : rtData;

  aluUnit aluUnit_inst (
    .a      (rsData),
    .b      (aluB),
    .op     (ctrl.aluOp),
    .result (aluResult),
    .zero   (aluZero)
  );

  pcUnit pcUnit_inst (
    .clk      (clk),
    .rst      (rst),
    .ctrl     (ctrl),
    .zero     (aluZero),
    .imm      (instrView.i.imm),
    .target   (instrView.j.target),
    .rsData   (rsData),
    .pc       (instrAddr),
    .linkAddr (linkAddr)
  );

  // ====================================================================
  // memory access and write-back
  // ====================================================================
  // word address from byte address bits 8..2
  assign dmemReq.addr  = aluResult[`DMEM_AW+1:2];
  assign dmemReq.wdata = rtData;
  assign dmemReq.we    = ctrl.memWrite & rst;
  assign dmemReq.re    = ctrl.memRead & rst;

  // link overrides rd/rt
  always_comb begin
    if (ctrl.link) begin
      destReg = `LINK_REG;
    end else if (ctrl.regDst) begin
      destReg = instr.rd;
    end else begin
      destReg = instr.rt;
    end
  end

  // jal return address, load data or ALU result
  always_comb begin
    if (ctrl.link) begin
      wbData = linkAddr;
    end else if (ctrl.memToReg) begin
      wbData = dmemRdata;
    end else begin
      wbData = aluResult;
    end
  end

  assign wb.en   = ctrl.regWrite & rst;
  assign wb.addr = destReg;
  assign wb.data = wbData;

endmodule

// ==== source/mipsIsaPkg.sv ====
/* Instruction-set types for the supported MIPS subset only.
   Unlisted opcodes and functs decode to no operation in the core. */
package mipsIsaPkg;

  // ====================================================================
  // opcode and funct encodings
  // ====================================================================
  typedef enum logic [5:0] {
    opRtype = 6'h00,
    opJ     = 6'h02,
    opJal   = 6'h03,
    opBeq   = 6'h04,
    opLw    = 6'h23,
    opSw    = 6'h2b
  } opcodeT;

  // R-type funct field
  typedef enum logic [5:0] {
    fnJr  = 6'h08,
    fnAdd = 6'h20,
    fnSub = 6'h22,
    fnAnd = 6'h24,
    fnOr  = 6'h25,
    fnSlt = 6'h2a
  } functT;

  // ====================================================================
  // instruction word views
  // ====================================================================
  typedef struct packed {
    opcodeT      op;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [4:0]  shamt;
    functT       funct;
  } instrT;

  // I-format overlay
  typedef struct packed {
    opcodeT      op;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] imm;
  } iFieldsT;

  // J-format overlay
  typedef struct packed {
    opcodeT      op;
    logic [25:0] target;
  } jFieldsT;

  typedef union packed {
    instrT   r;
    iFieldsT i;
    jFieldsT j;
  } instrU;

  // ALU operation select
  typedef enum logic [2:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluOr,
    aluSlt,
    aluPass
  } aluOpT;

endpackage

// ==== source/mips_consts.svh ====
/* Core-wide constants. The data memory is word addressed with DMEM_AW bits,
   so only the low 2^DMEM_AW words are reachable. */
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

// datapath and address width
`define XLEN 32

// architectural register count
`define REG_COUNT 32

// jal writes its return address here
`define LINK_REG 5'd31

// first fetch address after reset
`define RESET_PC 32'h0000_0000

// data memory word address width (result bits 8..2)
`define DMEM_AW 7

`endif

// ==== source/pcUnit.sv ====
/* Program counter with next-PC selection, one instruction per clock.
   Priority is jr, then j/jal, then taken beq, then PC+4. */
`timescale 1ns/1ps
`include "mips_consts.svh"

module pcUnit import mipsBusPkg::*; (
  input  logic             clk,
  input  logic             rst,
  input  ctrlT             ctrl,
  input  logic             zero,
  input  logic [15:0]      imm,
  input  logic [25:0]      target,
  input  logic [`XLEN-1:0] rsData,
  output logic [`XLEN-1:0] pc,
  output logic [`XLEN-1:0] linkAddr
);

  logic [`XLEN-1:0] pcPlus4;
  logic [`XLEN-1:0] branchAddr;
  logic [`XLEN-1:0] jumpAddr;
  logic [`XLEN-1:0] pcNext;

  // ====================================================================
  // candidate addresses
  // ====================================================================
  assign pcPlus4    = pc + `XLEN'd4;
  // simm << 2 relative to PC+4
  assign branchAddr = pcPlus4 + {{(`XLEN-18){imm[15]}}, imm, 2'b00};
  // region bits kept from PC+4
  assign jumpAddr   = {pcPlus4[`XLEN-1:`XLEN-4], target, 2'b00};
  // jal return address is PC+8
  assign linkAddr   = pc + `XLEN'd8;

  always_comb begin
    if (ctrl.jumpReg) begin
      pcNext = rsData;
    end else if (ctrl.jump) begin
      pcNext = jumpAddr;
    end else if (ctrl.branch && zero) begin
      pcNext = branchAddr;
    end else begin
      pcNext = pcPlus4;
    end
  end

  // PC register
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pc <= `RESET_PC;
    end else begin
      pc <= pcNext;
    end
  end

endmodule

// ==== source/regFile.sv ====
/* 32 x 32 register file, two combinational reads and one write per clock.
   r0 always reads zero; a write to it is dropped. */
`timescale 1ns/1ps
`include "mips_consts.svh"

module regFile import mipsBusPkg::*; (
  input  logic             clk,
  input  logic             rst,
  input  logic [4:0]       rs,
  input  logic [4:0]       rt,
  input  wbT               wb,
  output logic [`XLEN-1:0] rsData,
  output logic [`XLEN-1:0] rtData
);

  // ====================================================================
  // storage
  // ====================================================================
  logic [`XLEN-1:0] regs [`REG_COUNT];

  // whole file cleared on reset
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.en && (wb.addr != 5'd0)) begin
      regs[wb.addr] <= wb.data;
    end
  end

  // ====================================================================
  // read ports
  // ====================================================================
  // no bypass, a same-cycle write shows next cycle
  assign rsData = (rs == 5'd0) ? '0 : regs[rs];
  assign rtData = (rt == 5'd0) ? '0 : regs[rt];

endmodule

// ==== test/coreTb.sv ====
/* Testbench for mipsCore with both memories modelled here. An architectural
   model steps in lockstep with the DUT and is checked at every rising edge.
   The program stays inside the first 64 instruction words. */
`timescale 1ns/1ps
`include "mips_consts.svh"

module coreTb import mipsIsaPkg::*, mipsBusPkg::*; ();

  localparam int progLen       = 28;
  localparam int imemWords     = 64;
  localparam int dmemWords     = 1 << `DMEM_AW;
  localparam int timeoutCycles = progLen * 2 + 20;

  // expected outputs of one instruction plus the model's next PC
  typedef struct packed {
    wbT               wb;
    dmemReqT          mem;
    logic [`XLEN-1:0] nextPc;
  } expectT;

  logic             clk;
  logic             rst;
  logic [`XLEN-1:0] instrAddr;
  instrT            instr;
  dmemReqT          dmemReq;
  logic [`XLEN-1:0] dmemRdata;
  wbT               wb;

  logic [`XLEN-1:0] imem [imemWords];
  logic [`XLEN-1:0] dmem [dmemWords];
  logic [`XLEN-1:0] dmemInit [dmemWords];

  // reference model state
  logic [`XLEN-1:0] mRegs [`REG_COUNT];
  logic [`XLEN-1:0] mMem [dmemWords];
  logic [`XLEN-1:0] mPc;

  int checks [5];
  int errs [5];
  int totalChecks;
  int totalErrs;
  int cycleCount;

  mipsCore mipsCore_inst (
    .clk       (clk),
    .rst       (rst),
    .instrAddr (instrAddr),
    .instr     (instr),
    .dmemReq   (dmemReq),
    .dmemRdata (dmemRdata),
    .wb        (wb)
  );

  // ====================================================================
  // memories
  // ====================================================================
  // combinational fetch by word index
  assign instr     = instrT'(imem[instrAddr[7:2]]);
  assign dmemRdata = dmem[dmemReq.addr];

  // image reloaded in reset and stores on the rising edge
  always @(posedge clk) begin
    if (!rst) begin
      for (int i = 0; i < dmemWords; i++) begin
        dmem[i] <= dmemInit[i];
      end
    end else if (dmemReq.we) begin
      dmem[dmemReq.addr] <= dmemReq.wdata;
    end
  end

  // ====================================================================
  // instruction encoders
  // ====================================================================
  function automatic logic [31:0] rWord(functT fn, logic [4:0] rd, logic [4:0] rs,
                                        logic [4:0] rt);
    return {opRtype, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic logic [31:0] iWord(opcodeT op, logic [4:0] rs, logic [4:0] rt,
                                        logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic logic [31:0] jWord(opcodeT op, logic [25:0] target);
    return {op, target};
  endfunction

  // ====================================================================
  // reference model
  // ====================================================================
  function automatic expectT modelStep(input logic [31:0] iw);
    expectT           e;
    logic [4:0]       rs;
    logic [4:0]       rt;
    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    logic [`XLEN-1:0] simm;
    logic [`XLEN-1:0] ea;
    logic [`XLEN-1:0] pc4;
    rs   = iw[25:21];
    rt   = iw[20:16];
    a    = mRegs[rs];
    b    = mRegs[rt];
    simm = {{16{iw[15]}}, iw[15:0]};
    ea   = a + simm;
    pc4  = mPc + 32'd4;
    e    = '0;
    e.nextPc = pc4;
    case (iw[31:26])
      opRtype: begin
        e.wb.en   = 1'b1;
        e.wb.addr = iw[15:11];
        case (iw[5:0])
          fnAdd: e.wb.data = a + b;
          fnSub: e.wb.data = a - b;
          fnAnd: e.wb.data = a & b;
          fnOr:  e.wb.data = a | b;
          // signed compare
          fnSlt: e.wb.data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          fnJr: begin
            e.wb.en  = 1'b0;
            e.nextPc = a;
          end
          default: e.wb.en = 1'b0;
        endcase
      end
      opLw: begin
        e.mem.re   = 1'b1;
        e.mem.addr = ea[`DMEM_AW+1:2];
        e.wb.en    = 1'b1;
        e.wb.addr  = rt;
        e.wb.data  = mMem[ea[`DMEM_AW+1:2]];
      end
      opSw: begin
        e.mem.we    = 1'b1;
        e.mem.addr  = ea[`DMEM_AW+1:2];
        e.mem.wdata = b;
      end
      // taken when equal with a word offset from PC+4
      opBeq: if (a == b) e.nextPc = pc4 + {simm[29:0], 2'b00};
      opJ:   e.nextPc = {pc4[31:28], iw[25:0], 2'b00};
      opJal: begin
        e.nextPc  = {pc4[31:28], iw[25:0], 2'b00};
        e.wb.en   = 1'b1;
        e.wb.addr = `LINK_REG;
        e.wb.data = mPc + 32'd8;
      end
      default: ;
    endcase
    // commit architectural state with r0 kept at zero
    if (e.wb.en && (e.wb.addr != 5'd0)) mRegs[e.wb.addr] = e.wb.data;
    if (e.mem.we) mMem[e.mem.addr] = e.mem.wdata;
    return e;
  endfunction

  // program region of each reported test
  function automatic int sectionOf(input logic [`XLEN-1:0] pc);
    if (pc[7:2] < 6'd8) return 1;
    if (pc[7:2] < 6'd16) return 2;
    if (pc[7:2] < 6'd22) return 3;
    return 4;
  endfunction

  task automatic compareValue(input string name, input logic [31:0] got,
                              input logic [31:0] expVal, input int sec);
    checks[sec]++;
    totalChecks++;
    assert (got === expVal) else begin
      errs[sec]++;
      totalErrs++;
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, expVal);
    end
  endtask

  task automatic reportSection(input int sec);
    string label;
    case (sec)
      0:       label = "reset";
      1:       label = "memory";
      2:       label = "alu";
      3:       label = "branch";
      default: label = "jump";
    endcase
    $display("test %s: %0d checks, %0d errors, %s", label, checks[sec], errs[sec],
             (errs[sec] == 0) ? "passed" : "failed");
  endtask

  // ====================================================================
  // clock, stimulus and program image
  // ====================================================================
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    rst = 1'b0;
    void'($urandom(27));
    for (int i = 0; i < dmemWords; i++) begin
      dmemInit[i] = $urandom;
    end
    // r1 negative and r2 positive so slt tells signed from unsigned
    dmemInit[0][31] = 1'b1;
    dmemInit[1][31] = 1'b0;
    // pointer word holding the 0x40 base for rs-relative accesses
    dmemInit[dmemWords-1] = 32'h0000_0040;
    // unused words jump to themselves
    for (int w = 0; w < imemWords; w++) begin
      imem[w] = jWord(opJ, 26'(w));
    end
    // loads and stores
    imem[0]  = iWord(opLw, 5'd0, 5'd1, 16'd0);
    imem[1]  = iWord(opLw, 5'd0, 5'd2, 16'd4);
    imem[2]  = iWord(opLw, 5'd0, 5'd3, 16'd8);
    imem[3]  = iWord(opLw, 5'd0, 5'd11, 16'd508);
    imem[4]  = iWord(opSw, 5'd11, 5'd1, 16'd8);
    imem[5]  = iWord(opSw, 5'd11, 5'd2, 16'hfffc);
    imem[6]  = iWord(opLw, 5'd11, 5'd12, 16'd8);
    imem[7]  = iWord(opLw, 5'd11, 5'd13, 16'hfffc);
    // R-type then a write to r0 read back
    imem[8]  = rWord(fnAdd, 5'd4, 5'd1, 5'd2);
    imem[9]  = rWord(fnSub, 5'd5, 5'd1, 5'd2);
    imem[10] = rWord(fnAnd, 5'd6, 5'd1, 5'd3);
    imem[11] = rWord(fnOr, 5'd7, 5'd2, 5'd3);
    imem[12] = rWord(fnSlt, 5'd8, 5'd1, 5'd2);
    imem[13] = rWord(fnSlt, 5'd9, 5'd2, 5'd1);
    imem[14] = rWord(fnAdd, 5'd0, 5'd1, 5'd2);
    imem[15] = rWord(fnAdd, 5'd10, 5'd0, 5'd1);
    // not taken at 16 then taken to 20 and back to 18 before j to 22
    imem[16] = iWord(opBeq, 5'd1, 5'd2, 16'd5);
    imem[17] = iWord(opBeq, 5'd1, 5'd1, 16'd2);
    imem[18] = rWord(fnAdd, 5'd14, 5'd1, 5'd1);
    imem[19] = jWord(opJ, 26'd22);
    imem[20] = iWord(opBeq, 5'd0, 5'd0, 16'hfffd);
    imem[21] = rWord(fnAdd, 5'd15, 5'd1, 5'd1);
    // call to 26 returns to word 24
    imem[22] = jWord(opJal, 26'd26);
    imem[23] = rWord(fnOr, 5'd17, 5'd1, 5'd2);
    imem[24] = iWord(opSw, 5'd11, 5'd16, 16'd12);
    imem[25] = jWord(opJ, 26'd25);
    imem[26] = rWord(fnAdd, 5'd16, 5'd1, 5'd3);
    imem[27] = rWord(fnJr, 5'd0, 5'd31, 5'd0);
    repeat (5) @(negedge clk);
    rst = 1'b1;
  end

  // ====================================================================
  // comparison against the model
  // ====================================================================
  initial begin
    expectT           e;
    int               curSec;
    logic             done;
    logic [`XLEN-1:0] iw;
    @(posedge clk);
    while (!rst) begin
      compareValue("instrAddr", instrAddr, `RESET_PC, 0);
      compareValue("wb.en", 32'(wb.en), 32'd0, 0);
      compareValue("dmemReq.we", 32'(dmemReq.we), 32'd0, 0);
      @(posedge clk);
    end
    reportSection(0);
    for (int i = 0; i < `REG_COUNT; i++) begin
      mRegs[i] = '0;
    end
    for (int i = 0; i < dmemWords; i++) begin
      mMem[i] = dmemInit[i];
    end
    mPc    = `RESET_PC;
    curSec = 1;
    done   = 1'b0;
    while (!done) begin
      iw = imem[mPc[7:2]];
      if (sectionOf(mPc) != curSec) begin
        reportSection(curSec);
        curSec = sectionOf(mPc);
      end
      e = modelStep(iw);
      compareValue("instrAddr", instrAddr, mPc, curSec);
      compareValue("wb.en", 32'(wb.en), 32'(e.wb.en), curSec);
      if (e.wb.en) begin
        compareValue("wb.addr", 32'(wb.addr), 32'(e.wb.addr), curSec);
        compareValue("wb.data", wb.data, e.wb.data, curSec);
      end
      compareValue("dmemReq.we", 32'(dmemReq.we), 32'(e.mem.we), curSec);
      compareValue("dmemReq.re", 32'(dmemReq.re), 32'(e.mem.re), curSec);
      if (e.mem.we || e.mem.re) begin
        compareValue("dmemReq.addr", 32'(dmemReq.addr), 32'(e.mem.addr), curSec);
      end
      if (e.mem.we) compareValue("dmemReq.wdata", dmemReq.wdata, e.mem.wdata, curSec);
      // self-jump marks the end of the program
      done = (e.nextPc == mPc);
      mPc  = e.nextPc;
      if (!done) @(posedge clk);
    end
    reportSection(curSec);
    $display("%0d checks, %0d errors", totalChecks, totalErrs);
    if (totalErrs == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  // run limit from the program length
  initial begin
    cycleCount = 0;
    while (cycleCount < timeoutCycles) begin
      @(posedge clk);
      cycleCount++;
    end
    $display("timeout: program end not reached within %0d cycles", timeoutCycles);
    $display("Test FAILED");
    $finish;
  end

endmodule
